// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // ****************************************
    // Cache geometry
    // ****************************************
    localparam int LINE_NUM       = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_SIZE      = WORDS_PER_LINE * 32;
    localparam int OFFSET_WIDTH   = $clog2(LINE_SIZE / 8);
    localparam int INDEX_WIDTH    = $clog2(LINE_NUM);

    // Bit 31 of the byte address is not carried to memory.
    localparam int LINE_ADDR_WIDTH = 32 - OFFSET_WIDTH - 1;
    localparam int TAG_WIDTH       = LINE_ADDR_WIDTH - INDEX_WIDTH;

    // ****************************************
    // Types
    // ****************************************
    typedef logic [31:0]             addr_t;
    typedef logic [31:0]             word_t;
    typedef logic [LINE_SIZE-1:0]    line_t; // Word i sits at bits [32*i +: 32].
    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;

endpackage

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    localparam int MEM_LINES      = 1024;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_LINES);
    localparam int MEM_LATENCY    = 4;   // Start pulse to complete pulse, in cycles.
    localparam int MEM_CNT_WIDTH  = $clog2(MEM_LATENCY);

    localparam logic [31:0] MEM_INIT_KEY = 32'hC0DE0000;

    typedef logic [cache_pkg::LINE_ADDR_WIDTH-1:0] line_addr_t;

    typedef enum logic {
        MODE_READ  = 1'b0,
        MODE_WRITE = 1'b1
    } handle_mode_t;

    // Power-up contents of the backing memory, one word per byte address.
    function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t a);
        return a ^ MEM_INIT_KEY;
    endfunction

endpackage

// ==== rtl/bram.sv ====
module bram #(
    parameter int DATA_WIDTH = 32,
    parameter int DATA_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(DATA_DEPTH)-1:0] addr,
    input  logic [DATA_WIDTH-1:0]         d,
    output logic [DATA_WIDTH-1:0]         q
);

    logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= d;
            q         <= d;        // Write-first, the new data shows on q.
        end else begin
            q <= mem[addr];
        end
    end

endmodule

// ==== rtl/cache_controller.sv ====
module cache_controller (
    input  logic                  clk,
    input  logic                  rstn,
    input  cache_pkg::addr_t      addr,
    input  cache_pkg::word_t      din,
    input  logic                  re,
    input  logic                  we,
    output cache_pkg::word_t      dout,
    output logic                  data_valid,
    output mem_pkg::line_addr_t   handle_addr,
    output mem_pkg::handle_mode_t handle_mode,
    output cache_pkg::line_t      wline,
    output logic                  handle_start,
    input  cache_pkg::line_t      rline,
    input  logic                  handle_complete
);

    import cache_pkg::*;
    import mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_BACK,
        LINE_FETCH,
        LINE_FILL,
        COMPLETE
    } state_t;

    state_t                    state;
    logic                      waiting;
    logic                      lookup;
    index_t                    index;
    tag_t                      tag;
    logic [OFFSET_WIDTH-3:0]   word_sel;
    logic [WORDS_PER_LINE-1:0] word_hot;
    logic [TAG_WIDTH+1:0]      tag_d;
    logic [TAG_WIDTH+1:0]      tag_q;
    logic                      tag_we;
    tag_t                      stored_tag;
    logic                      stored_dirty;
    logic                      stored_valid;
    logic [LINE_NUM-1:0]       line_valid;
    logic                      valid;
    logic                      hit;
    logic                      miss;
    logic                      fill;
    line_t                     fill_line;
    word_t                     data_d [WORDS_PER_LINE];
    word_t                     data_q [WORDS_PER_LINE];
    logic [WORDS_PER_LINE-1:0] data_we;

    assign index    = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag      = addr[OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
    assign word_sel = addr[OFFSET_WIDTH-1:2];
    assign word_hot = WORDS_PER_LINE'(1) << word_sel;

    assign {stored_tag, stored_dirty, stored_valid} = tag_q;
    assign valid = stored_valid && line_valid[index];

    // The RAM outputs belong to the current request only while lookup is high.
    assign hit  = lookup && valid && (stored_tag == tag);
    assign miss = lookup && !hit;

    assign data_valid = hit;
    assign dout       = data_q[word_sel];
    assign fill       = (state == LINE_FILL);

    assign tag_we = fill || (hit && we);
    assign tag_d  = {tag, we, 1'b1};

    // The evicted line goes out under its own tag during write-back.
    assign handle_addr = (state == WRITE_BACK) ? {stored_tag, index} : {tag, index};

    // ****************************************
    // Data and tag arrays
    // ****************************************
    for (genvar i = 0; i < WORDS_PER_LINE; i++) begin : g_word
        assign data_we[i] = fill || (hit && we && word_hot[i]);
        assign data_d[i]  = (we && word_hot[i]) ? din : fill_line[i*$bits(word_t) +: $bits(word_t)];
        assign wline[i*$bits(word_t) +: $bits(word_t)] = data_q[i];

        bram #(
            .DATA_WIDTH($bits(word_t)),
            .DATA_DEPTH(LINE_NUM)
        ) i_data_ram (
            .clk  (clk),
            .we   (data_we[i]),
            .addr (index),
            .d    (data_d[i]),
            .q    (data_q[i])
        );
    end

    bram #(
        .DATA_WIDTH(TAG_WIDTH + 2),
        .DATA_DEPTH(LINE_NUM)
    ) i_tag_ram (
        .clk  (clk),
        .we   (tag_we),
        .addr (index),
        .d    (tag_d),
        .q    (tag_q)
    );

    // ****************************************
    // Request tracking
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            waiting    <= 1'b1;
            lookup     <= 1'b0;
            line_valid <= '0;
        end else begin
            if (waiting && (re || we)) begin
                waiting <= 1'b0;
            end else if (data_valid) begin
                waiting <= 1'b1;
            end
            // A new request or a finished fill is checked one cycle later.
            lookup <= (waiting && (re || we)) || (state == COMPLETE);
            if (fill) begin
                line_valid[index] <= 1'b1;
            end
        end
    end

    // ****************************************
    // Miss FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= IDLE;
            handle_start <= 1'b0;
            handle_mode  <= MODE_READ;
        end else begin
            handle_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (miss) begin
                        handle_start <= 1'b1;
                        if (valid && stored_dirty) begin
                            state       <= WRITE_BACK;
                            handle_mode <= MODE_WRITE;
                        end else begin
                            state       <= LINE_FETCH;
                            handle_mode <= MODE_READ;
                        end
                    end
                end
                WRITE_BACK: begin
                    if (handle_complete) begin
                        state        <= LINE_FETCH;
                        handle_start <= 1'b1;
                        handle_mode  <= MODE_READ;
                    end
                end
                LINE_FETCH: begin
                    if (handle_complete) begin
                        state <= LINE_FILL;
                    end
                end
                LINE_FILL: state <= COMPLETE;
                COMPLETE:  state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LINE_FETCH && handle_complete) begin
            fill_line <= rline;
        end
    end

    // A transfer is only launched while the FSM waits for it.
    // A write-back only ever carries a valid dirty line.
    assert property (@(posedge clk) disable iff (!rstn)
        handle_start |-> state inside {WRITE_BACK, LINE_FETCH} &&
            (handle_mode == MODE_READ || (valid && stored_dirty)))
        else $error("handle_start in state %s", state.name());

    // Completion is only reported once the miss sequence has returned to IDLE.
    assert property (@(posedge clk) disable iff (!rstn)
        data_valid |-> state == IDLE)
        else $error("data_valid high in state %s", state);

endmodule

// ==== rtl/cache_miss_handler.sv ====
module cache_miss_handler (
    input  logic                  clk,
    input  logic                  rstn,
    input  mem_pkg::line_addr_t   handle_addr,
    input  mem_pkg::handle_mode_t handle_mode,
    input  cache_pkg::line_t      wline,
    input  logic                  handle_start,
    output cache_pkg::line_t      rline,
    output logic                  handle_complete
);

    import cache_pkg::*;
    import mem_pkg::*;

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t                    state;
    logic [MEM_CNT_WIDTH-1:0]  cnt;
    logic                      fire;
    logic [MEM_ADDR_WIDTH-1:0] mem_idx;
    line_t                     mem [MEM_LINES];

    assign mem_idx = handle_addr[MEM_ADDR_WIDTH-1:0]; // Upper line address bits alias.
    assign fire    = (state == BUSY) && (cnt == MEM_CNT_WIDTH'(1));

    // ****************************************
    // Latency counter
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state           <= IDLE;
            cnt             <= '0;
            handle_complete <= 1'b0;
        end else begin
            handle_complete <= fire;
            case (state)
                IDLE: begin
                    if (handle_start) begin
                        state <= BUSY;
                        cnt   <= MEM_CNT_WIDTH'(MEM_LATENCY - 1);
                    end
                end
                BUSY: begin
                    cnt <= cnt - MEM_CNT_WIDTH'(1);
                    if (fire) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ****************************************
    // Line memory
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_LINES; i++) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem[i][w*$bits(word_t) +: $bits(word_t)] <=
                        init_word(addr_t'((i << OFFSET_WIDTH) + (w << 2)));
                end
            end
        end else if (fire && handle_mode == MODE_WRITE) begin
            mem[mem_idx] <= wline;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && handle_mode == MODE_READ) begin
            rline <= mem[mem_idx];       // Valid together with handle_complete.
        end
    end

    // The controller waits for each transfer before starting the next.
    assert property (@(posedge clk) disable iff (!rstn)
        handle_start |-> state != BUSY)
        else $error("handle_start while a transfer is in progress");

endmodule

// ==== rtl/cache_top.sv ====
module cache_top (
    input  logic             clk,
    input  logic             rstn,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t din,
    input  logic             re,
    input  logic             we,
    output cache_pkg::word_t dout,
    output logic             data_valid
);

    import cache_pkg::*;
    import mem_pkg::*;

    line_addr_t   handle_addr;
    handle_mode_t handle_mode;
    line_t        wline;
    line_t        rline;
    logic         handle_start;
    logic         handle_complete;

    cache_controller i_controller (
        .clk             (clk),
        .rstn            (rstn),
        .addr            (addr),
        .din             (din),
        .re              (re),
        .we              (we),
        .dout            (dout),
        .data_valid      (data_valid),
        .handle_addr     (handle_addr),
        .handle_mode     (handle_mode),
        .wline           (wline),
        .handle_start    (handle_start),
        .rline           (rline),
        .handle_complete (handle_complete)
    );

    // Stands in for the DRAM side of the cache.
    cache_miss_handler i_miss_handler (
        .clk             (clk),
        .rstn            (rstn),
        .handle_addr     (handle_addr),
        .handle_mode     (handle_mode),
        .wline           (wline),
        .handle_start    (handle_start),
        .rline           (rline),
        .handle_complete (handle_complete)
    );

endmodule

// ==== tb/tb_cache.sv ====
module tb_cache;

    import cache_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int QUIET_CYCLES    = 6;
    localparam int CYCLES_PER_LINE = 200;

    logic  clk;
    logic  rstn;
    addr_t addr;
    word_t din;
    logic  re;
    logic  we;
    word_t dout;
    logic  data_valid;

    logic [7:0] op_q [$];
    addr_t      addr_q [$];
    word_t      wdata_q [$];
    word_t      exp_q [$];
    int         n_stim;
    int         pulses;
    logic       stim_loaded;

    cache_top i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .addr       (addr),
        .din        (din),
        .re         (re),
        .we         (we),
        .dout       (dout),
        .data_valid (data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ****************************************
    // Checks and stimulus helpers
    // ****************************************
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic load_stim();
        int              fd;
        int              n;
        logic [8*120-1:0] line_buf;
        logic [7:0]      op;
        addr_t           a;
        word_t           wd;
        word_t           ev;
        fd = $fopen("tb/cache_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/cache_stim.txt.");
            $display("Some tests failed");
            $fatal(1, "missing stimulus file");
        end
        line_buf = '0;
        while ($fgets(line_buf, fd) != 0) begin
            n = $sscanf(line_buf, "%s %h %h %h", op, a, wd, ev);
            if (n == 4) begin
                if (op != "R" && op != "W") begin
                    $display("The stimulus file holds an unknown operation %s.", op);
                    $display("Some tests failed");
                    $fatal(1, "bad stimulus line");
                end
                op_q.push_back(op);
                addr_q.push_back(a);
                wdata_q.push_back(wd);
                exp_q.push_back(ev);
            end
            line_buf = '0;                  // Comment and blank lines fall through.
        end
        $fclose(fd);
        n_stim = op_q.size();
    endtask

    // One request, held until data_valid, then dropped for at least a cycle.
    task automatic run_request(input logic [7:0] op, input addr_t a, input word_t wd,
                               input word_t exp_val);
        @(posedge clk);
        addr <= a;
        din  <= wd;
        re   <= (op == "R");
        we   <= (op == "W");
        @(negedge clk);
        while (!data_valid) @(negedge clk);
        if (op == "R") begin
            check_value("dout", dout, exp_val);
        end
        @(posedge clk);
        re <= 1'b0;
        we <= 1'b0;
        @(negedge clk);
        check_value("data_valid", 32'(data_valid), 32'h0); // Pulse lasts one cycle.
    endtask

    // ****************************************
    // Main sequence
    // ****************************************
    initial begin : main
        int gap;
        void'($urandom(32'h54da));
        rstn        = 1'b0;
        re          = 1'b0;
        we          = 1'b0;
        addr        = '0;
        din         = '0;
        pulses      = 0;
        stim_loaded = 1'b0;
        load_stim();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("data_valid", 32'(data_valid), 32'h0);
        end
        for (int i = 0; i < n_stim; i++) begin
            run_request(op_q[i], addr_q[i], wdata_q[i], exp_q[i]);
            gap = $urandom % 4;
            repeat (gap) @(posedge clk);
        end
        check_value("data_valid pulses", pulses, n_stim);
        $display("All tests passed");
        $finish;
    end

    initial begin : pulse_counter
        forever begin
            @(negedge clk);
            if (rstn && data_valid) begin
                pulses++;
            end
        end
    end

    initial begin : watchdog
        wait (stim_loaded);
        repeat (RESET_CYCLES + QUIET_CYCLES + CYCLES_PER_LINE * n_stim) @(posedge clk);
        $display("Timeout: the requests did not complete in the allowed number of cycles.");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== flist.f ====
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/bram.sv
rtl/cache_controller.sv
rtl/cache_miss_handler.sv
rtl/cache_top.sv
tb/tb_cache.sv

// ==== Makefile ====
TOP := tb_cache

RTL := rtl/cache_pkg.sv rtl/mem_pkg.sv rtl/bram.sv rtl/cache_controller.sv \
       rtl/cache_miss_handler.sv rtl/cache_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

lint:
	verilator --lint-only $(RTL) --top-module cache_top
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== tb/cache_stim.txt ====
# op addr wdata expected, all hex, one request per line
# Writes ignore the expected column, reads ignore wdata
R 00000000 00000000 c0de0000
R 00000000 00000000 c0de0000
R 00000024 00000000 c0de0024
R 00000024 00000000 c0de0024
R 000001c8 00000000 c0de01c8
R 000001c8 00000000 c0de01c8
W 00000034 12345678 00000000
R 00000034 00000000 12345678
R 00000030 00000000 c0de0030
R 0000003c 00000000 c0de003c
W 00000054 deadbeef 00000000
R 00000554 00000000 c0de0554
R 00000054 00000000 deadbeef
R 00000058 00000000 c0de0058
R 00000100 00000000 c0de0100
R 00000000 00000000 c0de0000
W 00000054 0badf00d 00000000
R 00000054 00000000 0badf00d
R 00002054 00000000 c0de2054
R 00000054 00000000 0badf00d
